//--- verilog/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// address and entry geometry
`define MMU_VA_W    32
`define MMU_ENT_W   128
`define MMU_ACC_W   32

// set-associative array shape
`define MMU_SETS    64
`define MMU_IX_W    6

// no fault
`define EXC_NONE        16'h0000

// translation miss, software refills the TLB
`define EXC_TLBMISS     16'hA001

// user access into the uncached bypass region
`define EXC_BYP_LOAD    16'h8001
`define EXC_BYP_STORE   16'h8002

// page permission faults from the access checker
`define EXC_PRIV        16'h8003
`define EXC_WPROT       16'h8004
`define EXC_KEY         16'h8005
`define EXC_NOREAD      16'h8006

`endif

//--- verilog/mmuPkg.sv
package mmuPkg;

	// request operation on the L1/L2 memory port
	// loads carry bit 3, stores bit 4; TLB maintenance uses neither
	typedef enum logic [4:0]
	{
		opmNone   = 5'h00,
		opmLoad   = 5'h08,
		opmStore  = 5'h10,
		opmLdtlb  = 5'h01,   // fill one entry from the data bus
		opmInvtlb = 5'h02    // flush the whole array
	} memOpm;

	// response status toward L2
	typedef enum logic [1:0]
	{
		okReady = 2'b00,   // idle, nothing done
		okOk    = 2'b01    // operation accepted
	} memOk;

	// control register select for write and readback
	typedef enum logic [1:0]
	{
		selMmcr = 2'd0,   // MMU control
		selKrr  = 2'd1,   // keyring
		selSr   = 2'd2    // status
	} ctrlSel;

endpackage

//--- verilog/mmuCtrlRegs.sv
module mmuCtrlRegs (
	input  logic           clock,
	input  logic           arstN,
	input  logic           regWrite,
	input  mmuPkg::ctrlSel regSel,
	input  logic [63:0]    regWdata,
	output logic [63:0]    regRdata,
	output logic [63:0]    mmcr,
	output logic [63:0]    krr,
	output logic [63:0]    sr
);
	import mmuPkg::*;

	logic [63:0] mmcrQ;
	logic [63:0] krrQ;
	logic [63:0] srQ;

	// all zero out of reset, so the MMU starts disabled in user mode
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			mmcrQ <= '0;
			krrQ  <= '0;
			srQ   <= '0;
		end
		else if (regWrite)
		begin
			case (regSel)
				selMmcr: mmcrQ <= regWdata;
				selKrr:  krrQ  <= regWdata;
				selSr:   srQ   <= regWdata;
				default: ;   // unused select, write dropped
			endcase
		end
	end

	// readback follows the select with no delay
	always_comb
	begin
		case (regSel)
			selMmcr: regRdata = mmcrQ;
			selKrr:  regRdata = krrQ;
			selSr:   regRdata = srQ;
			default: regRdata = '0;
		endcase
	end

	assign mmcr = mmcrQ;
	assign krr  = krrQ;
	assign sr   = srQ;

endmodule

//--- verilog/mmuChkAcc.sv
`include "mmu_consts.svh"

module mmuChkAcc (
	input  logic [`MMU_ACC_W-1:0] accField,
	input  mmuPkg::memOpm         opm,
	input  logic [63:0]           mmcr,
	input  logic [63:0]           krr,
	input  logic [63:0]           sr,
	output logic [15:0]           excCode
);
	import mmuPkg::*;

	// access field as packed by the TLB
	// key in 31:16, extended mode in 15:4, mode in 3:0
	logic [15:0] entKey;
	logic [3:0]  entMode;
	logic        supOnly;
	logic        noWrite;
	logic        noRead;
	logic        userMode;
	logic        keyChkEn;
	logic        isLoad;
	logic        isStore;
	logic        keyBad;

	assign entKey  = accField[31:16];
	assign entMode = accField[3:0];

	assign supOnly = entMode[0];
	assign noWrite = entMode[1];
	assign noRead  = entMode[2];

	assign userMode = !sr[30];
	assign keyChkEn = mmcr[1];

	assign isLoad  = (opm == opmLoad);
	assign isStore = (opm == opmStore);

	// key zero marks a page open to every key
	assign keyBad = keyChkEn && (entKey != 16'h0000) && (entKey != krr[15:0]);

	// first matching fault wins
	always_comb
	begin
		excCode = `EXC_NONE;
		if (isLoad || isStore)
		begin
			if (userMode && supOnly)
			begin
				excCode = `EXC_PRIV;
			end
			else if (isStore && noWrite)
			begin
				excCode = `EXC_WPROT;
			end
			else if (isLoad && noRead)
			begin
				excCode = `EXC_NOREAD;
			end
			else if (keyBad)
			begin
				excCode = `EXC_KEY;
			end
		end
	end

endmodule

//--- verilog/mmuTlb.sv
`include "mmu_consts.svh"

module mmuTlb (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic [`MMU_VA_W-1:0]  addrIn,
	input  logic [`MMU_ENT_W-1:0] dataIn,
	input  mmuPkg::memOpm         opmIn,
	input  logic [63:0]           mmcr,
	input  logic [63:0]           krr,
	input  logic [63:0]           sr,
	input  logic [15:0]           chkExc,
	output logic [`MMU_ACC_W-1:0] accField,
	output logic [`MMU_VA_W-1:0]  addrOut,
	output mmuPkg::memOpm         opmOut,
	output mmuPkg::memOk          okOut,
	output logic [63:0]           excOut
);
	import mmuPkg::*;

	localparam int NumWays = 4;

	// way 0 is A, the most recent fill
	logic [`MMU_ENT_W-1:0] wayMem [NumWays][`MMU_SETS];
	logic [`MMU_SETS-1:0]  flushMask;   // set bit hides the whole set

	logic [`MMU_IX_W-1:0]  setIx;
	logic [`MMU_ENT_W-1:0] wayDat [NumWays];
	logic [NumWays-1:0]    wayHit;
	logic                  hit;
	logic [1:0]            hitWay;
	logic [`MMU_VA_W-1:0]  xlatAddr;

	logic                  mmuOn;
	logic                  bypass;
	logic                  userMode;
	logic                  isLoad;
	logic                  isStore;
	logic                  isLdtlb;
	logic                  isInvtlb;

	logic [`MMU_VA_W-1:0]  addrNext;
	logic [15:0]           excNext;
	memOk                  okNext;

	// hashed set index spreads neighbouring 64K regions
	assign setIx = addrIn[17:12] ^ addrIn[21:16];

	assign mmuOn    = mmcr[0];
	assign bypass   = addrIn[31];   // uncached window, never translated
	assign userMode = !sr[30];

	assign isLoad   = (opmIn == opmLoad);
	assign isStore  = (opmIn == opmStore);
	assign isLdtlb  = (opmIn == opmLdtlb);
	assign isInvtlb = (opmIn == opmInvtlb);

	// read all ways of the set, valid bit masked by the flush state
	always_comb
	begin
		for (int w = 0; w < NumWays; w++)
		begin
			wayDat[w]    = wayMem[w][setIx];
			wayDat[w][0] = wayMem[w][setIx][0] & ~flushMask[setIx];
			wayHit[w]    = wayDat[w][0] && (wayDat[w][95:76] == addrIn[31:12]);
		end
	end

	// walk from D down to A so A has the final say
	always_comb
	begin
		hit    = |wayHit;
		hitWay = 2'd3;
		for (int w = NumWays - 1; w >= 0; w--)
		begin
			if (wayHit[w])
			begin
				hitWay = w[1:0];
			end
		end
	end

	// key, extended mode and mode of the selected way
	assign accField = {wayDat[hitWay][127:112], wayDat[hitWay][75:64], wayDat[hitWay][7:4]};
	assign xlatAddr = {wayDat[hitWay][31:12], addrIn[11:0]};

	always_comb
	begin
		addrNext = addrIn;   // pass-through unless translated
		excNext  = `EXC_NONE;
		if (mmuOn && !bypass)
		begin
			if (hit)
			begin
				addrNext = xlatAddr;
			end
			if (isLoad || isStore)
			begin
				excNext = hit ? chkExc : `EXC_TLBMISS;
			end
		end
		else if (mmuOn && userMode)
		begin
			// bypass window is supervisor only
			if (isLoad)
			begin
				excNext = `EXC_BYP_LOAD;
			end
			else if (isStore)
			begin
				excNext = `EXC_BYP_STORE;
			end
		end
	end

	always_comb
	begin
		case (opmIn)
			opmLoad, opmStore, opmLdtlb, opmInvtlb: okNext = okOk;
			default:                                okNext = okReady;
		endcase
	end

	// flush state, all sets empty after reset or INVTLB
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			flushMask <= '1;
		end
		else if (isInvtlb)
		begin
			flushMask <= '1;
		end
		else if (isLdtlb)
		begin
			flushMask[setIx] <= 1'b0;
		end
	end

	// registered response, TEA rides above the code
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			opmOut <= opmNone;
			okOut  <= okReady;
			excOut <= '0;
		end
		else
		begin
			opmOut <= opmIn;
			okOut  <= okNext;
			excOut <= {{(48 - `MMU_VA_W){1'b0}}, addrIn, excNext};
		end
	end

	always_ff @(posedge clock)
	begin
		addrOut <= addrNext;
		if (isLdtlb)
		begin
			// new entry into A, older ones age toward D
			wayMem[0][setIx] <= dataIn;
			for (int w = 1; w < NumWays; w++)
			begin
				wayMem[w][setIx] <= wayDat[w - 1];   // masked copy keeps flushed ways dead
			end
		end
	end

endmodule

//--- verilog/mmuTop.sv
`include "mmu_consts.svh"

module mmuTop (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic [`MMU_VA_W-1:0]  addrIn,
	input  logic [`MMU_ENT_W-1:0] dataIn,
	input  mmuPkg::memOpm         opmIn,
	output logic [`MMU_VA_W-1:0]  addrOut,
	output mmuPkg::memOpm         opmOut,
	output mmuPkg::memOk          okOut,
	output logic [63:0]           excOut,
	input  logic                  regWrite,
	input  mmuPkg::ctrlSel        regSel,
	input  logic [63:0]           regWdata,
	output logic [63:0]           regRdata
);

	logic [63:0]           mmcr;
	logic [63:0]           krr;
	logic [63:0]           sr;
	logic [`MMU_ACC_W-1:0] accField;   // hit way permissions
	logic [15:0]           chkExc;

	mmuCtrlRegs i_ctrlRegs (
		.clock    (clock),
		.arstN    (arstN),
		.regWrite (regWrite),
		.regSel   (regSel),
		.regWdata (regWdata),
		.regRdata (regRdata),
		.mmcr     (mmcr),
		.krr      (krr),
		.sr       (sr)
	);

	mmuTlb i_tlb (
		.clock    (clock),
		.arstN    (arstN),
		.addrIn   (addrIn),
		.dataIn   (dataIn),
		.opmIn    (opmIn),
		.mmcr     (mmcr),
		.krr      (krr),
		.sr       (sr),
		.chkExc   (chkExc),
		.accField (accField),
		.addrOut  (addrOut),
		.opmOut   (opmOut),
		.okOut    (okOut),
		.excOut   (excOut)
	);

	// combinational loop-free, checker only sees the lookup result
	mmuChkAcc i_chkAcc (
		.accField (accField),
		.opm      (opmIn),
		.mmcr     (mmcr),
		.krr      (krr),
		.sr       (sr),
		.excCode  (chkExc)
	);

endmodule

//--- tb/tb_mmuTop.sv
`include "mmu_consts.svh"

module tb_mmuTop;
	timeunit 1ns;
	timeprecision 100ps;

	import mmuPkg::*;

	localparam int ResetTimeout = 20;   // cycles
	localparam logic [63:0] SupMode = 64'h0000_0000_4000_0000;

	// one table row holds a register write or a memory request
	typedef struct packed
	{
		logic                  isReg;
		ctrlSel                sel;
		logic [63:0]           wdata;
		memOpm                 opm;
		logic [`MMU_VA_W-1:0]  addr;
		logic [`MMU_ENT_W-1:0] data;
		logic [`MMU_VA_W-1:0]  expAddr;
		memOk                  expOk;
		logic [15:0]           expExc;
	} stimRow;

	logic                  clock;
	logic                  arstN;
	logic [`MMU_VA_W-1:0]  addrIn;
	logic [`MMU_ENT_W-1:0] dataIn;
	memOpm                 opmIn;
	logic [`MMU_VA_W-1:0]  addrOut;
	memOpm                 opmOut;
	memOk                  okOut;
	logic [63:0]           excOut;
	logic                  regWrite;
	ctrlSel                regSel;
	logic [63:0]           regWdata;
	logic [63:0]           regRdata;

	stimRow      rows[$];
	logic [63:0] regShadow [4];   // expected register contents
	int          errCount;
	int          checkCount;
	int          waitCnt;

	mmuTop i_dut (
		.clock    (clock),
		.arstN    (arstN),
		.addrIn   (addrIn),
		.dataIn   (dataIn),
		.opmIn    (opmIn),
		.addrOut  (addrOut),
		.opmOut   (opmOut),
		.okOut    (okOut),
		.excOut   (excOut),
		.regWrite (regWrite),
		.regSel   (regSel),
		.regWdata (regWdata),
		.regRdata (regRdata)
	);

	always #5 clock = ~clock;

	initial
	begin
		arstN = 1'b0;
		repeat (3) @(posedge clock);
		arstN <= 1'b1;
	end

	// entry packed by the documented field layout
	function automatic logic [`MMU_ENT_W-1:0] makeEntry(input logic [19:0] vpn,
		input logic [19:0] ppn, input logic [3:0] mode, input logic [15:0] key);
		logic [`MMU_ENT_W-1:0] e;
		e          = '0;
		e[0]       = 1'b1;
		e[7:4]     = mode;
		e[31:12]   = ppn;
		e[95:76]   = vpn;
		e[127:112] = key;
		return e;
	endfunction

	task automatic addRegWrite(input ctrlSel sel, input logic [63:0] wdata);
		stimRow r;
		r.isReg   = 1'b1;
		r.sel     = sel;
		r.wdata   = wdata;
		r.opm     = opmNone;
		r.addr    = '0;   // page 0 is never mapped
		r.data    = '0;
		r.expAddr = '0;
		r.expOk   = okReady;
		r.expExc  = `EXC_NONE;
		rows.push_back(r);
	endtask

	task automatic addRequest(input memOpm opm, input logic [31:0] addr,
		input logic [127:0] data, input logic [31:0] expAddr, input logic [15:0] expExc);
		stimRow r;
		r.isReg   = 1'b0;
		r.sel     = selMmcr;
		r.wdata   = '0;
		r.opm     = opm;
		r.addr    = addr;
		r.data    = data;
		r.expAddr = expAddr;
		r.expOk   = (opm == opmNone) ? okReady : okOk;
		r.expExc  = expExc;
		rows.push_back(r);
	endtask

	task automatic buildTable();
		// readback and plain pass-through with the MMU off
		addRegWrite(selKrr, 64'h1234_5678_9abc_def0);
		addRegWrite(selSr, SupMode);
		addRegWrite(selSr, 64'h0);
		addRequest(opmLoad, 32'h1234_5678, '0, 32'h1234_5678, `EXC_NONE);
		addRequest(opmStore, 32'h8000_1000, '0, 32'h8000_1000, `EXC_NONE);
		addRequest(opmLoad, 32'h0001_0abc, '0, 32'h0001_0abc, `EXC_NONE);
		// miss then fill with the MMU on
		addRegWrite(selMmcr, 64'h1);
		addRequest(opmLoad, 32'h1234_5678, '0, 32'h1234_5678, `EXC_TLBMISS);
		addRequest(opmLdtlb, 32'h1234_5000, makeEntry(20'h12345, 20'h00abc, 4'h0, 16'h0),
			32'h1234_5000, `EXC_NONE);
		addRequest(opmLoad, 32'h1234_5678, '0, 32'h00ab_c678, `EXC_NONE);
		addRequest(opmStore, 32'h1234_5ffc, '0, 32'h00ab_cffc, `EXC_NONE);
		// five pages on set 0x11 push the oldest out
		addRequest(opmLdtlb, 32'h0001_0000, makeEntry(20'h00010, 20'h0f001, 4'h0, 16'h0),
			32'h0001_0000, `EXC_NONE);
		addRequest(opmLdtlb, 32'h0041_0000, makeEntry(20'h00410, 20'h0f002, 4'h0, 16'h0),
			32'h0041_0000, `EXC_NONE);
		addRequest(opmLdtlb, 32'h0081_0000, makeEntry(20'h00810, 20'h0f003, 4'h0, 16'h0),
			32'h0081_0000, `EXC_NONE);
		addRequest(opmLdtlb, 32'h00c1_0000, makeEntry(20'h00c10, 20'h0f004, 4'h0, 16'h0),
			32'h00c1_0000, `EXC_NONE);
		addRequest(opmLoad, 32'h0001_0010, '0, 32'h0f00_1010, `EXC_NONE);
		addRequest(opmLoad, 32'h0041_0020, '0, 32'h0f00_2020, `EXC_NONE);
		addRequest(opmLoad, 32'h0081_0030, '0, 32'h0f00_3030, `EXC_NONE);
		addRequest(opmLoad, 32'h00c1_0040, '0, 32'h0f00_4040, `EXC_NONE);
		addRequest(opmLdtlb, 32'h0101_0000, makeEntry(20'h01010, 20'h0f005, 4'h0, 16'h0),
			32'h0101_0000, `EXC_NONE);
		addRequest(opmLoad, 32'h0001_0010, '0, 32'h0001_0010, `EXC_TLBMISS);
		addRequest(opmLoad, 32'h0101_0050, '0, 32'h0f00_5050, `EXC_NONE);
		addRequest(opmLoad, 32'h0041_0060, '0, 32'h0f00_2060, `EXC_NONE);
		// flush and a single reload
		addRequest(opmInvtlb, 32'h8000_0000, '0, 32'h8000_0000, `EXC_NONE);
		addRequest(opmLoad, 32'h0041_0060, '0, 32'h0041_0060, `EXC_TLBMISS);
		addRequest(opmLoad, 32'h1234_5678, '0, 32'h1234_5678, `EXC_TLBMISS);
		addRequest(opmLdtlb, 32'h0081_0000, makeEntry(20'h00810, 20'h0f003, 4'h0, 16'h0),
			32'h0081_0000, `EXC_NONE);
		addRequest(opmLoad, 32'h0081_0030, '0, 32'h0f00_3030, `EXC_NONE);
		addRequest(opmLoad, 32'h00c1_0040, '0, 32'h00c1_0040, `EXC_TLBMISS);   // was way B
		addRequest(opmLoad, 32'h1234_5678, '0, 32'h1234_5678, `EXC_TLBMISS);
		// permission faults use one page per set
		addRequest(opmLdtlb, 32'h0002_1000, makeEntry(20'h00021, 20'h0a021, 4'b0001, 16'h0),
			32'h0002_1000, `EXC_NONE);
		addRequest(opmLoad, 32'h0002_1004, '0, 32'h0a02_1004, `EXC_PRIV);
		addRegWrite(selSr, SupMode);
		addRequest(opmLoad, 32'h0002_1004, '0, 32'h0a02_1004, `EXC_NONE);
		addRegWrite(selSr, 64'h0);
		addRequest(opmLdtlb, 32'h0002_2000, makeEntry(20'h00022, 20'h0a022, 4'b0010, 16'h0),
			32'h0002_2000, `EXC_NONE);
		addRequest(opmStore, 32'h0002_2008, '0, 32'h0a02_2008, `EXC_WPROT);
		addRequest(opmLoad, 32'h0002_2008, '0, 32'h0a02_2008, `EXC_NONE);
		addRequest(opmLdtlb, 32'h0002_3000, makeEntry(20'h00023, 20'h0a023, 4'b0100, 16'h0),
			32'h0002_3000, `EXC_NONE);
		addRequest(opmLoad, 32'h0002_300c, '0, 32'h0a02_300c, `EXC_NOREAD);
		addRequest(opmStore, 32'h0002_300c, '0, 32'h0a02_300c, `EXC_NONE);
		addRequest(opmLdtlb, 32'h0002_4000, makeEntry(20'h00024, 20'h0a024, 4'h0, 16'h5a5a),
			32'h0002_4000, `EXC_NONE);
		addRequest(opmLoad, 32'h0002_4010, '0, 32'h0a02_4010, `EXC_NONE);   // key check off
		addRegWrite(selMmcr, 64'h3);
		addRequest(opmLoad, 32'h0002_4010, '0, 32'h0a02_4010, `EXC_KEY);
		addRegWrite(selKrr, 64'h5a5a);
		addRequest(opmLoad, 32'h0002_4010, '0, 32'h0a02_4010, `EXC_NONE);
		// bypass window in user then supervisor mode
		addRequest(opmLoad, 32'h8000_0040, '0, 32'h8000_0040, `EXC_BYP_LOAD);
		addRequest(opmStore, 32'h8001_2340, '0, 32'h8001_2340, `EXC_BYP_STORE);
		addRegWrite(selSr, SupMode);
		addRequest(opmLoad, 32'h8000_0040, '0, 32'h8000_0040, `EXC_NONE);
		addRequest(opmStore, 32'h8001_2340, '0, 32'h8001_2340, `EXC_NONE);
		addRequest(opmNone, 32'h0000_0100, '0, 32'h0000_0100, `EXC_NONE);
	endtask

	task automatic reportMismatch(input int idx, input string name,
		input logic [63:0] expVal, input logic [63:0] actVal);
		$display("CHECK FAILED time=%0t row=%0d %s expected=%h actual=%h",
			$time, idx, name, expVal, actVal);
		errCount++;
	endtask

	task automatic checkResponse(input stimRow r, input int idx);
		checkCount += 5;
		assert (addrOut == r.expAddr)
			else reportMismatch(idx, "addrOut", 64'(r.expAddr), 64'(addrOut));
		assert (opmOut == r.opm)
			else reportMismatch(idx, "opmOut", 64'(r.opm), 64'(opmOut));
		assert (okOut == r.expOk)
			else reportMismatch(idx, "okOut", 64'(r.expOk), 64'(okOut));
		assert (excOut[15:0] == r.expExc)
			else reportMismatch(idx, "excOut code", 64'(r.expExc), 64'(excOut[15:0]));
		assert (excOut[63:16] == {16'h0000, r.addr})   // TEA is the request address
			else reportMismatch(idx, "excOut tea", 64'(r.addr), 64'(excOut[63:16]));
	endtask

	task automatic checkReadback(input int idx);
		checkCount++;
		assert (regRdata == regShadow[regSel])
			else reportMismatch(idx, "regRdata", regShadow[regSel], regRdata);
	endtask

	// row i goes in on edge i and its response is sampled half a cycle after edge i+1
	task automatic runTable();
		int n;
		n = rows.size();
		for (int i = 0; i <= n; i++)
		begin
			@(posedge clock);
			if (i < n)
			begin
				regWrite <= rows[i].isReg;
				if (rows[i].isReg)
				begin
					regSel <= rows[i].sel;   // readback keeps the last select
				end
				regWdata <= rows[i].wdata;
				opmIn    <= rows[i].opm;
				addrIn   <= rows[i].addr;
				dataIn   <= rows[i].data;
			end
			else
			begin
				regWrite <= 1'b0;
				opmIn    <= opmNone;
				addrIn   <= '0;
				dataIn   <= '0;
			end
			@(negedge clock);
			if (i > 0)
			begin
				checkResponse(rows[i - 1], i - 1);
			end
			checkReadback(i);
			if (i < n && rows[i].isReg)
			begin
				regShadow[rows[i].sel] = rows[i].wdata;   // lands on the next edge
			end
		end
	endtask

	initial
	begin
		clock      = 1'b0;
		addrIn     = 32'h1234_5678;   // pending load that reset must hold off
		dataIn     = '0;
		opmIn      = opmLoad;
		regWrite   = 1'b0;
		regSel     = selMmcr;
		regWdata   = '0;
		errCount   = 0;
		checkCount = 0;
		waitCnt    = 0;
		for (int k = 0; k < 4; k++)
		begin
			regShadow[k] = '0;
		end
		buildTable();
		@(negedge clock);
		// response held idle while arstN is low
		checkCount += 3;
		assert (okOut == okReady)
			else reportMismatch(-1, "okOut", 64'(okReady), 64'(okOut));
		assert (excOut == 64'h0)
			else reportMismatch(-1, "excOut", 64'h0, excOut);
		assert (opmOut == opmNone)
			else reportMismatch(-1, "opmOut", 64'(opmNone), 64'(opmOut));
		while (arstN !== 1'b1 && waitCnt < ResetTimeout)
		begin
			@(posedge clock);
			waitCnt++;
		end
		if (arstN !== 1'b1)
		begin
			$display("reset was still asserted after %0d cycles", ResetTimeout);
			$display("SIMULATION FAILED");
			$finish;
		end
		else
		begin
			runTable();
			$display("rows: %0d checks: %0d errors: %0d", rows.size(), checkCount, errCount);
			if (errCount == 0)
			begin
				$display("SIMULATION PASSED");
			end
			else
			begin
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

endmodule

//--- vlog.f
+incdir+verilog
verilog/mmuPkg.sv
verilog/mmuCtrlRegs.sv
verilog/mmuChkAcc.sv
verilog/mmuTlb.sv
verilog/mmuTop.sv
tb/tb_mmuTop.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide the result from the simulation log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f --top-module tb_mmuTop \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_mmuTop > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no pass line found in sim.log"; exit 1; }
exit 0
